// File: hw/apple1_pkg.sv
/*
 * Shared constants and the key word type for the Apple 1 serial terminal path.
 * Modules refer to everything here by scoped name, apple1_pkg::name.
 */
package apple1_pkg;

    // serial timing in clk25 cycles per bit (simulation baud)
    localparam int clks_per_bit = 16;
    localparam int bit_cnt_w = $clog2(clks_per_bit);
    // last cycle of a full bit and of half a bit
    localparam logic [bit_cnt_w-1:0] bit_end = bit_cnt_w'(clks_per_bit - 1);
    localparam logic [bit_cnt_w-1:0] half_bit_end = bit_cnt_w'(clks_per_bit / 2 - 1);

    // key buffer geometry
    localparam int fifo_depth = 16;
    localparam int fifo_aw = 4;
    // cts drops at this fill, 4 slots left for bytes already on the wire
    localparam int cts_threshold = 12;
    localparam logic [fifo_aw:0] fifo_full_cnt = (fifo_aw + 1)'(fifo_depth);
    localparam logic [fifo_aw:0] cts_cnt = (fifo_aw + 1)'(cts_threshold);

    // idle time after each displayed character, mimics the slow Apple 1 screen
    localparam int char_gap_cycles = 400;
    localparam int gap_cnt_w = $clog2(char_gap_cycles);
    localparam logic [gap_cnt_w-1:0] gap_end = gap_cnt_w'(char_gap_cycles - 1);

    localparam logic [7:0] ascii_cr = 8'h0d;

    // receiver states
    localparam logic [1:0] rx_st_idle = 2'd0;
    localparam logic [1:0] rx_st_start = 2'd1;
    localparam logic [1:0] rx_st_data = 2'd2;
    localparam logic [1:0] rx_st_stop = 2'd3;

    // echo states
    localparam logic [1:0] tx_st_idle = 2'd0;
    localparam logic [1:0] tx_st_filter = 2'd1;
    localparam logic [1:0] tx_st_send = 2'd2;
    localparam logic [1:0] tx_st_gap = 2'd3;

    // one byte, seen raw or as keyboard strobe plus 7-bit ascii
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       strobe;
            logic [6:0] ascii;
        } key;
    } key_word_u;

endpackage

// File: hw/uart_receiver.sv
/*
 * 8N1 serial receiver for bytes typed on the host.
 * Each frame with a good stop bit gives a one-cycle rx_valid strobe
 * with the byte on rx_data; broken frames are dropped without notice.
 */
module uart_receiver (
    input  logic       clk25,
    input  logic       arst_n,
    input  logic       uart_rx,
    output logic       rx_valid,
    output logic [7:0] rx_data
);

    // two-flop synchronizer plus one more stage for edge detect
    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    logic [1:0]                       state;
    logic [apple1_pkg::bit_cnt_w-1:0] bit_cnt;
    logic [2:0]                       bit_idx;
    logic                             bit_done;

    // byte under assembly, lsb arrives first
    apple1_pkg::key_word_u shift_word;

    always_ff @(posedge clk25 or negedge arst_n) begin
        if (!arst_n) begin
            // line idles high
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // last cycle of a full bit period
    assign bit_done = (bit_cnt == apple1_pkg::bit_end);

    always_ff @(posedge clk25 or negedge arst_n) begin
        if (!arst_n) begin
            state    <= apple1_pkg::rx_st_idle;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            // strobe lasts one cycle only
            rx_valid <= 1'b0;
            case (state)
                apple1_pkg::rx_st_idle: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    // falling edge starts a frame
                    if (rx_prev && !rx_sync) begin
                        state <= apple1_pkg::rx_st_start;
                    end
                end
                apple1_pkg::rx_st_start: begin
                    if (bit_cnt == apple1_pkg::half_bit_end) begin
                        bit_cnt <= '0;
                        // glitch, line went back high before mid start bit
                        if (rx_sync) begin
                            state <= apple1_pkg::rx_st_idle;
                        end else begin
                            state <= apple1_pkg::rx_st_data;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                apple1_pkg::rx_st_data: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= apple1_pkg::rx_st_stop;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                apple1_pkg::rx_st_stop: begin
                    if (bit_done) begin
                        // framing check, low stop bit means no strobe
                        rx_valid <= rx_sync;
                        state    <= apple1_pkg::rx_st_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= apple1_pkg::rx_st_idle;
            endcase
        end
    end

    // sample mid data bit, shift in from the top
    always_ff @(posedge clk25) begin
        if (state == apple1_pkg::rx_st_data && bit_done) begin
            shift_word.raw <= {rx_sync, shift_word.raw[7:1]};
        end
    end

    // byte holds still from the stop bit until the next frame's first data bit
    assign rx_data = shift_word.raw;

endmodule

// File: hw/key_fifo.sv
/*
 * Key buffer between the serial receiver and the echo block.
 * Writes come as rx_valid strobes and are lost when full; the reader pops
 * the head shown on rd_data. uart_cts tells the host to hold off.
 */
module key_fifo (
    input  logic       clk25,
    input  logic       arst_n,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    input  logic       pop,
    output logic [7:0] rd_data,
    output logic       empty,
    output logic       uart_cts
);

    // key storage
    logic [7:0] mem [apple1_pkg::fifo_depth];

    logic [apple1_pkg::fifo_aw-1:0] wr_ptr;
    logic [apple1_pkg::fifo_aw-1:0] rd_ptr;
    // one bit wider than the pointers so full and empty differ
    logic [apple1_pkg::fifo_aw:0]   count;

    logic full;
    logic wr_en;
    logic rd_en;

    assign full  = (count == apple1_pkg::fifo_full_cnt);
    assign empty = (count == '0);

    // writes into a full buffer are dropped
    // the host should have seen cts low by then
    assign wr_en = rx_valid && !full;
    // pop on an empty buffer leaves the pointers alone
    assign rd_en = pop && !empty;

    // head entry always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk25) begin
        if (wr_en) begin
            mem[wr_ptr] <= rx_data;
        end
    end

    always_ff @(posedge clk25 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap naturally since the depth is a power of two
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                // fill stays put on both or neither
                default: count <= count;
            endcase
        end
    end

    // clear to send is registered from the current fill
    always_ff @(posedge clk25 or negedge arst_n) begin
        if (!arst_n) begin
            uart_cts <= 1'b1;
        end else begin
            uart_cts <= (count < apple1_pkg::cts_cnt);
        end
    end

endmodule

// File: hw/terminal_echo.sv
/*
 * Terminal echo that drains the key buffer and sends what the Apple 1 screen
 * would show back to the host on uart_tx.
 * Bit 7 is ignored and lower case folds to upper case. Control codes other
 * than carriage return are dropped, and so is delete. Output is paced per character.
 */
module terminal_echo (
    input  logic       clk25,
    input  logic       arst_n,
    input  logic       empty,
    input  logic [7:0] rd_data,
    output logic       pop,
    output logic       uart_tx
);

    logic [1:0] state;

    // latched key where only the 7-bit view matters
    apple1_pkg::key_word_u char_word;

    logic [6:0] folded;
    logic       keep;

    // frame shifts out lsb first with the start bit in bit 0
    logic [9:0]                       tx_shift;
    logic [apple1_pkg::bit_cnt_w-1:0] bit_cnt;
    logic [3:0]                       bit_idx;
    logic [apple1_pkg::gap_cnt_w-1:0] gap_cnt;

    // take the head as soon as we are free and something waits
    assign pop = (state == apple1_pkg::tx_st_idle) && !empty;

    always_ff @(posedge clk25) begin
        if (pop) begin
            char_word.raw <= rd_data;
        end
    end

    // display filter ignores the strobe bit
    always_comb begin
        folded = char_word.key.ascii;
        // a..z to A..Z by clearing bit 5
        if (char_word.key.ascii >= 7'h61 && char_word.key.ascii <= 7'h7a) begin
            folded = char_word.key.ascii & 7'h5f;
        end
        // printable range without delete plus carriage return
        keep = (char_word.key.ascii >= 7'h20 && char_word.key.ascii != 7'h7f)
            || ({1'b0, char_word.key.ascii} == apple1_pkg::ascii_cr);
    end

    always_ff @(posedge clk25 or negedge arst_n) begin
        if (!arst_n) begin
            state    <= apple1_pkg::tx_st_idle;
            tx_shift <= '1;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            gap_cnt  <= '0;
        end else begin
            case (state)
                apple1_pkg::tx_st_idle: begin
                    // pop is high in this same cycle
                    if (!empty) begin
                        state <= apple1_pkg::tx_st_filter;
                    end
                end
                apple1_pkg::tx_st_filter: begin
                    if (keep) begin
                        // stop bit on top of data with bit 7 clear and the start bit
                        tx_shift <= {1'b1, 1'b0, folded, 1'b0};
                        bit_cnt  <= '0;
                        bit_idx  <= '0;
                        state    <= apple1_pkg::tx_st_send;
                    end else begin
                        // nothing to show so fetch the next key
                        state <= apple1_pkg::tx_st_idle;
                    end
                end
                apple1_pkg::tx_st_send: begin
                    if (bit_cnt == apple1_pkg::bit_end) begin
                        bit_cnt <= '0;
                        // ones fill in behind so the line idles after the stop bit
                        tx_shift <= {1'b1, tx_shift[9:1]};
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 4'd9) begin
                            gap_cnt <= '0;
                            state   <= apple1_pkg::tx_st_gap;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                apple1_pkg::tx_st_gap: begin
                    // display speed hold off
                    if (gap_cnt == apple1_pkg::gap_end) begin
                        state <= apple1_pkg::tx_st_idle;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: state <= apple1_pkg::tx_st_idle;
            endcase
        end
    end

    // line is high whenever no frame is going out
    assign uart_tx = tx_shift[0];

endmodule

// File: hw/apple1_serial_top.sv
/*
 * Serial terminal path of the Apple 1, clocked by clk25.
 * Host bytes come in on uart_rx, are buffered, and the displayable
 * form is echoed on uart_tx; uart_cts throttles the host.
 */
module apple1_serial_top (
    input  logic clk25,
    input  logic arst_n,
    input  logic uart_rx,
    output logic uart_tx,
    output logic uart_cts
);

    // receiver to buffer
    logic       rx_valid;
    logic [7:0] rx_data;

    // buffer to echo
    logic       pop;
    logic [7:0] rd_data;
    logic       empty;

    uart_receiver u_uart_receiver (
        .clk25    (clk25),
        .arst_n   (arst_n),
        .uart_rx  (uart_rx),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    // buffer also owns clear to send
    key_fifo u_key_fifo (
        .clk25    (clk25),
        .arst_n   (arst_n),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .pop      (pop),
        .rd_data  (rd_data),
        .empty    (empty),
        .uart_cts (uart_cts)
    );

    terminal_echo u_terminal_echo (
        .clk25   (clk25),
        .arst_n  (arst_n),
        .empty   (empty),
        .rd_data (rd_data),
        .pop     (pop),
        .uart_tx (uart_tx)
    );

endmodule

// File: verification/apple1_serial_checker.sv
/*
 * Concurrent assertions on the key buffer, bound into key_fifo.
 * Watches pop against empty, the fill count and clear to send.
 */
module apple1_serial_checker (
    input logic                         clk25,
    input logic                         arst_n,
    input logic                         pop,
    input logic                         empty,
    input logic [apple1_pkg::fifo_aw:0] count,
    input logic                         uart_cts
);

    // reader may only take the head when something is there
    pop_not_empty: assert property (@(posedge clk25) disable iff (!arst_n) !(pop && empty))
        else $error("pop raised while the key buffer was empty");

    // fill never runs past the storage
    fill_bound: assert property (@(posedge clk25) disable iff (!arst_n)
        count <= apple1_pkg::fifo_full_cnt)
        else $error("key buffer fill count above its depth");

    // cts is registered, so it is low one cycle after the fill hits the threshold
    cts_drop: assert property (@(posedge clk25) disable iff (!arst_n)
        (count >= apple1_pkg::cts_cnt) |=> !uart_cts)
        else $error("uart_cts still high one cycle after the fill reached the threshold");

    // first clock after reset release sees an empty buffer
    reset_empty: assert property (@(posedge clk25) $rose(arst_n) |-> empty)
        else $error("key buffer not empty after reset");

endmodule

bind key_fifo apple1_serial_checker u_fifo_checker (
    .clk25    (clk25),
    .arst_n   (arst_n),
    .pop      (pop),
    .empty    (empty),
    .count    (count),
    .uart_cts (uart_cts)
);

// File: verification/apple1_serial_tb.sv
/*
 * Testbench for the Apple 1 serial terminal path.
 * Sends 8N1 frames on uart_rx, captures the echo on uart_tx and compares
 * it with a display filter model; ends with an error summary line.
 */
module apple1_serial_tb;

    localparam int bit_clks = apple1_pkg::clks_per_bit;
    // every byte sent over all tests, dropped ones included
    localparam int total_bytes = 65;
    localparam int timeout_cycles =
        total_bytes * (10 * bit_clks + apple1_pkg::char_gap_cycles + 20) * 2;

    // "APPLE1" then carriage return
    localparam logic [7:0] upper_keys [7] = '{8'h41, 8'h50, 8'h50, 8'h4c, 8'h45, 8'h31, 8'h0d};
    // lower case and bit 7 set
    localparam logic [7:0] fold_keys [6] = '{8'h61, 8'h7a, 8'h6d, 8'hc1, 8'he2, 8'hb5};
    // controls and delete between kept characters, 8d is a carriage return
    localparam logic [7:0] ctrl_keys [10] =
        '{8'h58, 8'h07, 8'h1b, 8'h7f, 8'h00, 8'h59, 8'h0a, 8'h5a, 8'h8d, 8'hff};

    logic clk25;
    logic arst_n;
    logic uart_rx;
    logic uart_tx;
    logic uart_cts;

    // expected echo, one name per character for error lines
    logic [7:0] exp_q [$];
    string      name_q [$];

    int errors;
    int cycles;
    int seed;
    logic in_burst;
    logic cts_low_seen;

    apple1_serial_top u_apple1_serial_top (
        .clk25    (clk25),
        .arst_n   (arst_n),
        .uart_rx  (uart_rx),
        .uart_tx  (uart_tx),
        .uart_cts (uart_cts)
    );

    initial begin
        clk25 = 1'b0;
        forever #4 clk25 = ~clk25;
    end

    // what the Apple 1 screen shows for a key, returns 0 when nothing shows
    function automatic logic display_char(input logic [7:0] code, output logic [7:0] shown);
        logic [7:0] c;
        c = code & 8'h7f;
        shown = c;
        if (c == 8'h7f) begin
            return 1'b0;
        end
        if (c < 8'h20 && c != apple1_pkg::ascii_cr) begin
            return 1'b0;
        end
        if (c >= 8'h61 && c <= 8'h7a) begin
            shown = c - 8'h20;
        end
        return 1'b1;
    endfunction

    // one 8N1 frame, stop bit value chosen by the caller
    task automatic send_frame(input logic [7:0] data, input logic stop_bit, input logic honor_cts);
        logic [9:0] frame;
        int i;
        frame = {stop_bit, data, 1'b0};
        @(posedge clk25);
        #1;
        // hold the start bit while the buffer asks us to wait
        if (honor_cts) begin
            while (!uart_cts) begin
                @(posedge clk25);
                #1;
            end
        end
        for (i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (bit_clks) @(posedge clk25);
            #1;
        end
        // bad frame leaves the line low, bring it back to idle
        if (!stop_bit) begin
            uart_rx = 1'b1;
            repeat (2 * bit_clks) @(posedge clk25);
            #1;
        end
    endtask

    task automatic send_key(input logic [7:0] code, input string name);
        logic [7:0] shown;
        if (display_char(code, shown)) begin
            exp_q.push_back(shown);
            name_q.push_back(name);
        end
        send_frame(code, 1'b1, 1'b1);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk25);
        end
    endtask

    task automatic check_char(input logic [7:0] got, input logic stop_bit);
        logic [7:0] exp_char;
        string name;
        assert (exp_q.size() != 0) else begin
            $display("character %02h appeared on uart_tx with nothing expected", got);
            errors++;
        end
        if (exp_q.size() != 0) begin
            exp_char = exp_q.pop_front();
            name = name_q.pop_front();
            assert (got == exp_char) else begin
                $display("[ERROR] %s: expected %02h, actual %02h", name, exp_char, got);
                errors++;
            end
            assert (stop_bit == 1'b1) else begin
                $display("[ERROR] %s: expected stop bit 1, actual %0b", name, stop_bit);
                errors++;
            end
        end
    endtask

    task automatic finish_run();
        int missing;
        missing = exp_q.size();
        if (missing != 0) begin
            $display("%0d expected characters never came back on uart_tx", missing);
        end
        $display("summary: %0d errors, %0d missing characters", errors, missing);
        if (errors == 0 && missing == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // echo capture, samples at the falling edge where uart_tx is stable
    initial begin : capture
        logic [7:0] got;
        logic stop_bit;
        int i;
        forever begin
            @(negedge clk25);
            if (!uart_tx) begin
                // move to mid start bit, then one bit time per sample
                repeat (bit_clks / 2) @(negedge clk25);
                for (i = 0; i < 8; i++) begin
                    repeat (bit_clks) @(negedge clk25);
                    got[i] = uart_tx;
                end
                repeat (bit_clks) @(negedge clk25);
                stop_bit = uart_tx;
                check_char(got, stop_bit);
            end
        end
    end

    always @(negedge clk25) begin
        if (in_burst && !uart_cts) begin
            cts_low_seen = 1'b1;
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk25);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d clock cycles", cycles);
        errors++;
        finish_run();
    end

    initial begin : stimulus
        int i;
        int rnd;
        logic [7:0] code;
        errors = 0;
        seed = 69739;
        in_burst = 1'b0;
        cts_low_seen = 1'b0;
        arst_n = 1'b0;
        uart_rx = 1'b1;
        repeat (8) @(posedge clk25);
        #1 arst_n = 1'b1;
        repeat (4 * bit_clks) @(posedge clk25);

        // one key at a time, each echo awaited
        for (i = 0; i < 7; i++) begin
            send_key(upper_keys[i], "upper_digits_cr");
            wait_drain();
        end

        for (i = 0; i < 6; i++) begin
            send_key(fold_keys[i], "lower_and_bit7");
        end
        wait_drain();

        for (i = 0; i < 10; i++) begin
            send_key(ctrl_keys[i], "control_drop");
        end
        wait_drain();

        // printable burst, fast enough to fill the buffer past the cts mark
        in_burst = 1'b1;
        for (i = 0; i < 40; i++) begin
            rnd = $random(seed);
            code = 8'h20 + 8'($unsigned(rnd) % 95);
            send_key(code, "random_burst");
        end
        in_burst = 1'b0;
        assert (cts_low_seen) else begin
            $display("[ERROR] random_burst: expected uart_cts low, actual never low");
            errors++;
        end
        wait_drain();

        // low stop bit, the frame must vanish
        send_frame(8'h51, 1'b0, 1'b0);
        send_key(8'h4b, "framing_error");
        wait_drain();

        // room for a stray character to show up
        repeat (apple1_pkg::char_gap_cycles + 12 * bit_clks) @(posedge clk25);
        finish_run();
    end

endmodule

// File: sim.f
hw/apple1_pkg.sv
hw/uart_receiver.sv
hw/key_fifo.sv
hw/terminal_echo.sv
hw/apple1_serial_top.sv
verification/apple1_serial_checker.sv
verification/apple1_serial_tb.sv

// File: Makefile
# Verilator build and run for the Apple 1 serial terminal path

SIM        ?= verilator
TOP        ?= apple1_serial_tb
FILELIST   ?= sim.f
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

build: $(BUILD_DIR)/V$(TOP)

# pass only when the log holds the pass line
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
